/* Makefile */
VERILATOR ?= verilator
TOP ?= mem_ctrl_tb
SRC_F ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(SRC_F) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(SRC_F) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

/* src.f */
+incdir+verilog
verilog/mc_pkg.sv
verilog/bank_arbiter.sv
verilog/burst_handler.sv
verilog/timing_controller.sv
verilog/row_store.sv
verilog/mem_ctrl_top.sv
testbench/mem_ctrl_tb.sv

/* testbench/mem_ctrl_tb.sv */
`timescale 1ns/1ps
`include "mc_macros.svh"

module mem_ctrl_tb;
	import mc_pkg::*;

	localparam int N_IDX = 2 ** `MC_INDEX_W;
	localparam int HALF = N_IDX / 2;          // tags per client
	localparam int DEPTH = 2 ** `MC_ADDR_W;
	localparam int N_RAND = 60;               // random requests per client
	localparam int N_STREAM = 8;              // one burst address each
	localparam int N_TOTAL = 4 + 2 * (N_RAND + N_STREAM);
	// activate, worst data latency, 16 beats, up to 16 returns, precharge
	localparam int WORST_BURST = 3 * `MC_ACT_TO_CMD + `MC_RD_TO_DATA
		+ 2 * `MC_BURST_LEN + 8;
	localparam int CYCLE_LIMIT = 40 + N_TOTAL * WORST_BURST;

	typedef struct packed {
		logic [1:0] gap;    // idle cycles after the strobe
		logic is_write;
		addr_t addr;
		data_t data;
	} req_t;

	logic clk, rst_n;
	logic req_valid [2], req_write [2], busy [2];
	addr_t req_addr [2];
	data_t req_data [2];
	index_t req_index [2];
	logic resp_valid;
	r_type resp_type;
	data_t resp_data;
	index_t resp_index;

	// scoreboard by tag
	logic pend [N_IDX];
	r_type exp_type [N_IDX];
	addr_t exp_addr [N_IDX];
	data_t exp_data [N_IDX];
	data_t ref_mem [DEPTH];     // follows write responses
	logic addr_pend [DEPTH];    // one request per address in flight

	req_t req_q [2][$];
	int gap_cnt [2];
	int busy_run [2];
	int busy_run_max;
	slot_t order_q [$];         // slots in response order
	int issued, answered, err_cnt, cycle_cnt;
	logic [31:0] seed;

	mem_ctrl_top mem_ctrl_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid_0(req_valid[0]),
		.req_write_0(req_write[0]),
		.req_addr_0(req_addr[0]),
		.req_data_0(req_data[0]),
		.req_index_0(req_index[0]),
		.busy_0(busy[0]),
		.req_valid_1(req_valid[1]),
		.req_write_1(req_write[1]),
		.req_addr_1(req_addr[1]),
		.req_data_1(req_data[1]),
		.req_index_1(req_index[1]),
		.busy_1(busy[1]),
		.resp_valid(resp_valid),
		.resp_type(resp_type),
		.resp_data(resp_data),
		.resp_index(resp_index)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic req_t make_req(input logic [1:0] gap, input logic is_write,
			input addr_t addr, input data_t data);
		req_t r;
		r.gap = gap;
		r.is_write = is_write;
		r.addr = addr;
		r.data = data;
		return r;
	endfunction

	// lowest idle tag of client c, -1 when all in flight
	function automatic int free_index(input int c);
		for (int i = 0; i < HALF; i++) begin
			if (!pend[c * HALF + i])
				return c * HALF + i;
		end
		return -1;
	endfunction

	task automatic drain();
		do
			@(negedge clk);
		while (req_q[0].size() != 0 || req_q[1].size() != 0 || issued != answered);
	endtask

	task automatic print_test_line(input string name, input int err_before);
		$display("test %s: %0d errors", name, err_cnt - err_before);
	endtask

	reset_quiet: assert property (@(posedge clk) $past(rst_n) |->
			!resp_valid && !busy[0] && !busy[1])
		else begin
			err_cnt++;
			$display("error resp_valid/busy in reset: resp_valid=%h busy_0=%h busy_1=%h",
				$sampled(resp_valid), $sampled(busy[0]), $sampled(busy[1]));
		end

	resp_known: assert property (@(posedge clk) disable iff (rst_n)
			resp_valid |-> pend[resp_index])
		else begin
			err_cnt++;
			$display("response for index %0d that has no outstanding request",
				$sampled(resp_index));
		end

	resp_type_ok: assert property (@(posedge clk) disable iff (rst_n)
			resp_valid && pend[resp_index] |-> resp_type == exp_type[resp_index])
		else begin
			err_cnt++;
			$display("error resp_type index %h: got %h expected %h", $sampled(resp_index),
				$sampled(resp_type), exp_type[$sampled(resp_index)]);
		end

	resp_data_ok: assert property (@(posedge clk) disable iff (rst_n)
			resp_valid && pend[resp_index] |-> resp_data == exp_data[resp_index])
		else begin
			err_cnt++;
			$display("error resp_data index %h: got %h expected %h", $sampled(resp_index),
				$sampled(resp_data), exp_data[$sampled(resp_index)]);
		end

	// retire responses, then launch at most one request per client
	always @(posedge clk) begin : drive_and_track
		logic claimed;
		addr_t claimed_addr;
		int idx;
		req_t r;
		claimed = 1'b0;
		claimed_addr = '0;
		if (!rst_n && resp_valid && pend[resp_index]) begin
			pend[resp_index] <= 1'b0;
			addr_pend[exp_addr[resp_index]] <= 1'b0;
			if (exp_type[resp_index] == write)
				ref_mem[exp_addr[resp_index]] <= exp_data[resp_index];
			order_q.push_back(exp_addr[resp_index][3:0]);
			answered++;
		end
		for (int c = 0; c < 2; c++) begin
			busy_run[c] = busy[c] ? busy_run[c] + 1 : 0;
			if (busy_run[c] > busy_run_max)
				busy_run_max = busy_run[c];
			req_valid[c] <= 1'b0;
			idx = free_index(c);
			if (gap_cnt[c] > 0) begin
				gap_cnt[c]--;
			end else if (!rst_n && !busy[c] && !req_valid[c] && req_q[c].size() != 0
					&& idx >= 0) begin
				r = req_q[c][0];
				// hold back while that address is still in flight
				if (!addr_pend[r.addr] && !(claimed && claimed_addr == r.addr)) begin
					void'(req_q[c].pop_front());
					req_valid[c] <= 1'b1;
					req_write[c] <= r.is_write;
					req_addr[c] <= r.addr;
					req_data[c] <= r.data;
					req_index[c] <= index_t'(idx);
					pend[idx] <= 1'b1;
					exp_type[idx] <= r.is_write ? write : read;
					exp_addr[idx] <= r.addr;
					exp_data[idx] <= r.is_write ? r.data : ref_mem[r.addr];   // echo or stored
					addr_pend[r.addr] <= 1'b1;
					gap_cnt[c] = r.gap;
					claimed = 1'b1;
					claimed_addr = r.addr;
					issued++;
				end
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, %0d of %0d requests answered",
			cycle_cnt, answered, issued);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		logic [31:0] rv;
		int e0;
		clk = 1'b0;
		rst_n = 1'b1;   // reset is active high
		seed = 32'h0dd1_3236;
		issued = 0;
		answered = 0;
		err_cnt = 0;
		busy_run_max = 0;
		for (int c = 0; c < 2; c++) begin
			req_valid[c] = 1'b0;
			req_write[c] = 1'b0;
			req_addr[c] = '0;
			req_data[c] = '0;
			req_index[c] = '0;
			gap_cnt[c] = 0;
			busy_run[c] = 0;
		end
		for (int i = 0; i < N_IDX; i++)
			pend[i] = 1'b0;
		for (int a = 0; a < DEPTH; a++) begin
			ref_mem[a] = '0;   // device powers up cleared
			addr_pend[a] = 1'b0;
		end

		repeat (10) @(posedge clk);
		rst_n <= 1'b0;
		repeat (3) @(negedge clk);
		print_test_line("reset", 0);

		// two strobes in one cycle, high slot granted first
		e0 = err_cnt;
		order_q.delete();
		req_q[0].push_back(make_req(2'd0, 1'b1, 12'h10c, 16'ha5c3));
		req_q[1].push_back(make_req(2'd0, 1'b1, 12'h103, 16'h3c5a));
		drain();
		req_q[0].push_back(make_req(2'd0, 1'b0, 12'h10c, 16'h0000));
		req_q[1].push_back(make_req(2'd0, 1'b0, 12'h103, 16'h0000));
		drain();
		slot_order: assert (order_q.size() == 4 && order_q[0] < order_q[1]
				&& order_q[2] < order_q[3])
			else begin
				err_cnt++;
				$display("merged burst did not return its slots in ascending order");
			end
		print_test_line("slot_order", e0);

		// mixed traffic over three burst addresses
		e0 = err_cnt;
		for (int i = 0; i < N_RAND; i++) begin
			for (int c = 0; c < 2; c++) begin
				seed = lcg(seed);
				rv = seed;
				seed = lcg(seed);
				req_q[c].push_back(make_req(rv[31:30], rv[29],
					{burst_addr_t'(8'h20 + rv[28:27] % 2'd3), slot_t'(rv[26:23])},
					seed[31:16]));
			end
		end
		drain();
		print_test_line("random", e0);

		// more burst addresses than entries, no gaps
		e0 = err_cnt;
		busy_run_max = 0;
		for (int i = 0; i < N_STREAM; i++) begin
			for (int c = 0; c < 2; c++) begin
				seed = lcg(seed);
				req_q[c].push_back(make_req(2'd0, !i[0],
					{burst_addr_t'(8'h40 + 2 * i + c), slot_t'(seed[31:28])},
					seed[27:12]));
			end
		end
		drain();
		stall_seen: assert (busy_run_max > 3)
			else begin
				err_cnt++;
				$display("busy never stayed high while all bursts were taken");
			end
		print_test_line("stream", e0);

		$display("requests %0d, responses %0d, errors %0d", issued, answered, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* verilog/bank_arbiter.sv */
`timescale 1ns/1ps
`include "mc_macros.svh"

module bank_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid_0, req_valid_1,
	input  logic req_write_0, req_write_1,
	input  mc_pkg::addr_t req_addr_0, req_addr_1,
	input  mc_pkg::data_t req_data_0, req_data_1,
	input  mc_pkg::index_t req_index_0, req_index_1,
	output logic busy_0, busy_1,
	input  logic [$bits(mc_pkg::burst_id_t):0] empty_bursts,
	input  mc_pkg::burst_addr_t fill_addr,   // address of the burst now filling
	output logic arb_valid,
	output mc_pkg::r_type arb_type,
	output mc_pkg::addr_t arb_addr,
	output mc_pkg::data_t arb_data,
	output mc_pkg::index_t arb_index
);
	import mc_pkg::*;

	localparam int BL = `MC_BURST_LEN;

	logic [1:0] in_valid, in_write;
	addr_t in_addr [2];
	data_t in_data [2];
	index_t in_index [2];

	logic [1:0] hold_full, hold_write;   // one-entry holder per client
	addr_t hold_addr [2];
	data_t hold_data [2];
	index_t hold_index [2];

	logic rr;          // client favoured when both holders are full
	logic pick;        // client presented this cycle
	logic extend;      // winner joins the filling burst
	logic run_live;    // a beat went out last cycle so the burst is still open
	r_type run_type;
	logic [BL-1:0] run_mask;   // mirror of the filling burst's slot mask

	assign in_valid = {req_valid_1, req_valid_0};
	assign in_write = {req_write_1, req_write_0};
	assign in_addr = '{req_addr_0, req_addr_1};
	assign in_data = '{req_data_0, req_data_1};
	assign in_index = '{req_index_0, req_index_1};
	assign busy_0 = hold_full[0];
	assign busy_1 = hold_full[1];

	always_comb begin
		pick = (hold_full == 2'b11) ? rr : hold_full[1];
		arb_addr = hold_addr[pick];
		arb_data = hold_data[pick];
		arb_index = hold_index[pick];
		arb_type = hold_write[pick] ? write : read;
		// same burst, same type and a free slot
		extend = run_live && arb_addr[`MC_ADDR_W-1:4] == fill_addr
			&& arb_type == run_type && !run_mask[arb_addr[3:0]];
		arb_valid = hold_full[pick] && (empty_bursts != '0 || extend);   // stall when no burst free
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			hold_full <= '0;
			rr <= 1'b0;
			run_live <= 1'b0;
		end else begin
			for (int c = 0; c < 2; c++) begin
				if (!hold_full[c] && in_valid[c])
					hold_full[c] <= 1'b1;
			end
			if (arb_valid) begin
				hold_full[pick] <= 1'b0;
				rr <= !pick;   // other client next time
			end
			run_live <= arb_valid;
		end
	end

	always_ff @(posedge clk) begin
		for (int c = 0; c < 2; c++) begin
			if (!hold_full[c] && in_valid[c]) begin
				hold_write[c] <= in_write[c];
				hold_addr[c] <= in_addr[c];
				hold_data[c] <= in_data[c];
				hold_index[c] <= in_index[c];
			end
		end
		if (arb_valid) begin
			run_type <= arb_type;
			run_mask <= (extend ? run_mask : '0) | (BL'(1) << arb_addr[3:0]);
		end
	end

endmodule

/* verilog/burst_handler.sv */
`timescale 1ns/1ps
`include "mc_macros.svh"

module burst_handler (
	input  logic clk,
	input  logic rst_n,
	input  logic arb_valid,
	input  mc_pkg::r_type arb_type,
	input  mc_pkg::addr_t arb_addr,
	input  mc_pkg::data_t arb_data,
	input  mc_pkg::index_t arb_index,
	output logic [$bits(mc_pkg::burst_id_t):0] empty_bursts,
	output mc_pkg::burst_addr_t fill_addr,
	output mc_pkg::burst_state_t [`MC_NO_OF_BURSTS-1:0] burst_state,
	output mc_pkg::r_type [`MC_NO_OF_BURSTS-1:0] burst_type,
	input  mc_pkg::command_t burst_cmd,
	input  mc_pkg::burst_id_t cmd_index,
	output logic mem_we,
	output mc_pkg::addr_t mem_addr,
	output mc_pkg::data_t mem_wdata,
	input  mc_pkg::data_t mem_rdata,
	output logic resp_valid,
	output mc_pkg::r_type resp_type,
	output mc_pkg::data_t resp_data,
	output mc_pkg::index_t resp_index
);
	import mc_pkg::*;

	localparam int NB = `MC_NO_OF_BURSTS;
	localparam int BL = `MC_BURST_LEN;
	localparam int CNT_W = $bits(burst_id_t) + 1;
	localparam int CW = $clog2(`MC_RD_TO_DATA + `MC_WR_TO_DATA + BL);

	burst_addr_t b_addr [NB];
	index_t b_index [NB][BL];
	data_t b_data [NB][BL];
	logic [BL-1:0] b_mask [NB];   // slots holding a request

	burst_id_t fill_id;
	logic fill_open;
	logic [3:0] fill_cnt;         // fills in the open burst

	slot_t slot;
	logic new_burst, alloc, free_burst;
	burst_id_t free_id, in_id;

	burst_id_t acc_id;            // burst in its data phase
	logic acc_busy, acc_write;
	logic [CW-1:0] dcnt, lat;
	logic beat_on;
	slot_t beat, addr_slot;

	logic ret_req;
	burst_id_t ret_id;
	logic [BL-1:0] low_bit;
	slot_t low_slot;

	assign fill_addr = b_addr[fill_id];

	always_comb begin
		slot = arb_addr[3:0];
		new_burst = !fill_open || arb_addr[`MC_ADDR_W-1:4] != b_addr[fill_id]
			|| arb_type != burst_type[fill_id] || b_mask[fill_id][slot];
		free_id = '0;
		for (int i = NB - 1; i >= 0; i--) begin
			if (burst_state[i] == empty)
				free_id = burst_id_t'(i);   // lowest empty wins
		end
		in_id = new_burst ? free_id : fill_id;
		alloc = arb_valid && new_burst;
	end

	always_comb begin
		ret_req = 1'b0;
		ret_id = '0;
		for (int i = NB - 1; i >= 0; i--) begin
			if (burst_state[i] == returning_data) begin
				ret_req = 1'b1;
				ret_id = burst_id_t'(i);
			end
		end
		low_bit = b_mask[ret_id] & (~b_mask[ret_id] + 1'b1);   // isolate lowest set slot
		low_slot = '0;
		for (int s = 0; s < BL; s++) begin
			if (low_bit[s])
				low_slot = slot_t'(s);
		end
		free_burst = ret_req && b_mask[ret_id] == '0;
	end

	always_comb begin
		lat = acc_write ? CW'(`MC_WR_TO_DATA) : CW'(`MC_RD_TO_DATA);
		beat_on = acc_busy && dcnt >= lat && dcnt < lat + CW'(BL);
		beat = slot_t'(dcnt - lat);
		// read address leads its data by the row store latency
		addr_slot = acc_write ? beat : slot_t'(dcnt - lat + 1'b1);
		mem_we = beat_on && acc_write && b_mask[acc_id][beat];   // masked slots only
		mem_addr = {b_addr[acc_id], addr_slot};
		mem_wdata = b_data[acc_id][beat];
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < NB; i++) begin
				burst_state[i] <= empty;
				b_mask[i] <= '0;
			end
			fill_open <= 1'b0;
			fill_id <= '0;
			fill_cnt <= '0;
			empty_bursts <= CNT_W'(NB);
			acc_busy <= 1'b0;
			dcnt <= '0;
			resp_valid <= 1'b0;
		end else begin
			if (arb_valid) begin
				if (new_burst) begin
					if (fill_open)
						burst_state[fill_id] <= full;   // old one closes
					burst_state[free_id] <= started_filling;
					b_mask[free_id] <= BL'(1) << slot;
					fill_id <= free_id;
					fill_cnt <= 4'd1;
				end else begin
					b_mask[fill_id][slot] <= 1'b1;
					fill_cnt <= fill_cnt + 4'd1;
					if (fill_cnt == 4'd7)
						burst_state[fill_id] <= almost_done;
				end
				fill_open <= 1'b1;
			end else if (fill_open) begin
				burst_state[fill_id] <= full;   // idle cycle ends the burst
				fill_open <= 1'b0;
			end
			empty_bursts <= empty_bursts - CNT_W'(alloc) + CNT_W'(free_burst);

			if (burst_cmd == activate)
				burst_state[cmd_index] <= accessing;
			if (burst_cmd == read_cmd || burst_cmd == write_cmd) begin
				acc_busy <= 1'b1;
				dcnt <= CW'(1);
			end else if (acc_busy) begin
				dcnt <= dcnt + 1'b1;
				if (beat_on && beat == 4'd15) begin
					acc_busy <= 1'b0;
					burst_state[acc_id] <= returning_data;
				end
			end

			resp_valid <= 1'b0;
			if (ret_req) begin
				if (free_burst) begin
					burst_state[ret_id] <= empty;
				end else begin
					resp_valid <= 1'b1;
					b_mask[ret_id][low_slot] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			burst_type[free_id] <= arb_type;
			b_addr[free_id] <= arb_addr[`MC_ADDR_W-1:4];
		end
		if (arb_valid) begin
			b_index[in_id][slot] <= arb_index;
			if (arb_type == write)
				b_data[in_id][slot] <= arb_data;
		end
		if (burst_cmd == read_cmd || burst_cmd == write_cmd) begin
			acc_id <= cmd_index;
			acc_write <= burst_cmd == write_cmd;
		end
		if (beat_on && !acc_write && b_mask[acc_id][beat])
			b_data[acc_id][beat] <= mem_rdata;
		resp_type <= burst_type[ret_id];
		resp_index <= b_index[ret_id][low_slot];
		resp_data <= b_data[ret_id][low_slot];   // write data echoes back
	end

endmodule

/* verilog/mc_macros.svh */
`ifndef MC_MACROS_SVH
`define MC_MACROS_SVH

// request side widths
`define MC_ADDR_W        12   // word address
`define MC_DATA_W        16   // one data word
`define MC_INDEX_W       4    // requester tag

// burst storage
`define MC_BURST_LEN     16   // slots per burst, fixed by the 4 slot bits
`define MC_NO_OF_BURSTS  4

// device latencies in clk cycles
`define MC_ACT_TO_CMD    3    // activate to read or write
`define MC_RD_TO_DATA    11   // read command to first beat
`define MC_WR_TO_DATA    8    // write command to first beat

`endif

/* verilog/mc_pkg.sv */
`include "mc_macros.svh"

package mc_pkg;

	typedef logic [`MC_ADDR_W-1:0] addr_t;       // word address with slot in the low bits
	typedef logic [`MC_ADDR_W-5:0] burst_addr_t; // address minus slot bits
	typedef logic [`MC_DATA_W-1:0] data_t;
	typedef logic [`MC_INDEX_W-1:0] index_t;     // tag echoed back in the response
	typedef logic [3:0] slot_t;                  // slot or beat number
	typedef logic [$clog2(`MC_NO_OF_BURSTS)-1:0] burst_id_t;

	typedef enum logic {read, write} r_type;

	// life of one burst entry
	typedef enum logic [2:0] {
		empty,
		started_filling,
		almost_done,     // eight or more fills
		full,            // closed, waits for the timing controller
		accessing,
		returning_data
	} burst_state_t;

	typedef enum logic [2:0] {none, activate, read_cmd, write_cmd, precharge} command_t;

endpackage

/* verilog/mem_ctrl_top.sv */
`timescale 1ns/1ps
`include "mc_macros.svh"

module mem_ctrl_top (
	input  logic clk,
	input  logic rst_n,
	input  logic req_valid_0, req_write_0,
	input  mc_pkg::addr_t req_addr_0,
	input  mc_pkg::data_t req_data_0,
	input  mc_pkg::index_t req_index_0,
	output logic busy_0,
	input  logic req_valid_1, req_write_1,
	input  mc_pkg::addr_t req_addr_1,
	input  mc_pkg::data_t req_data_1,
	input  mc_pkg::index_t req_index_1,
	output logic busy_1,
	output logic resp_valid,
	output mc_pkg::r_type resp_type,
	output mc_pkg::data_t resp_data,
	output mc_pkg::index_t resp_index
);
	import mc_pkg::*;

	// arbiter to burst handler
	logic arb_valid;
	r_type arb_type;
	addr_t arb_addr;
	data_t arb_data;
	index_t arb_index;
	logic [$bits(burst_id_t):0] empty_bursts;
	burst_addr_t fill_addr;

	// burst handler and command sequencer
	burst_state_t [`MC_NO_OF_BURSTS-1:0] burst_state;
	r_type [`MC_NO_OF_BURSTS-1:0] burst_type;
	command_t burst_cmd;
	burst_id_t cmd_index;

	// device side
	logic mem_we;
	addr_t mem_addr;
	data_t mem_wdata, mem_rdata;

	bank_arbiter bank_arbiter_i (.*);
	burst_handler burst_handler_i (.*);
	timing_controller timing_controller_i (.*);
	row_store row_store_i (.*);

endmodule

/* verilog/row_store.sv */
`timescale 1ns/1ps
`include "mc_macros.svh"

module row_store (
	input  logic clk,
	input  logic mem_we,
	input  mc_pkg::addr_t mem_addr,
	input  mc_pkg::data_t mem_wdata,
	output mc_pkg::data_t mem_rdata
);
	import mc_pkg::*;

	localparam int DEPTH = 2 ** `MC_ADDR_W;

	data_t mem [DEPTH];   // stands in for the device array

	// device starts out cleared
	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[mem_addr] <= mem_wdata;
		mem_rdata <= mem[mem_addr];   // one cycle read latency
	end

endmodule

/* verilog/timing_controller.sv */
`timescale 1ns/1ps
`include "mc_macros.svh"

module timing_controller (
	input  logic clk,
	input  logic rst_n,
	input  mc_pkg::burst_state_t [`MC_NO_OF_BURSTS-1:0] burst_state,
	input  mc_pkg::r_type [`MC_NO_OF_BURSTS-1:0] burst_type,
	output mc_pkg::command_t burst_cmd,   // one-cycle pulses
	output mc_pkg::burst_id_t cmd_index   // held for the whole sequence
);
	import mc_pkg::*;

	typedef enum logic [1:0] {idle, act_wait, access, pre_wait} tc_state_t;

	tc_state_t state;
	logic [3:0] wait_cnt;
	logic any_full;
	burst_id_t full_id;

	// lowest full burst goes first
	always_comb begin
		any_full = 1'b0;
		full_id = '0;
		for (int i = `MC_NO_OF_BURSTS - 1; i >= 0; i--) begin
			if (burst_state[i] == full) begin
				any_full = 1'b1;
				full_id = burst_id_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state <= idle;
			burst_cmd <= none;
			cmd_index <= '0;
			wait_cnt <= '0;
		end else begin
			burst_cmd <= none;
			wait_cnt <= wait_cnt + 4'd1;
			case (state)
				idle: begin
					if (any_full) begin
						burst_cmd <= activate;
						cmd_index <= full_id;
						wait_cnt <= 4'd1;
						state <= act_wait;
					end
				end
				act_wait: begin
					if (wait_cnt == 4'(`MC_ACT_TO_CMD)) begin   // row open
						burst_cmd <= (burst_type[cmd_index] == write) ? write_cmd : read_cmd;
						state <= access;
					end
				end
				access: begin
					if (burst_state[cmd_index] == returning_data) begin
						burst_cmd <= precharge;
						wait_cnt <= 4'd1;
						state <= pre_wait;
					end
				end
				pre_wait: begin
					// precharge recovery, taken equal to activate delay
					if (wait_cnt == 4'(`MC_ACT_TO_CMD))
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule
